// File: Makefile
# Verilator run of tb_rom_hub, pass decided from sim.log
sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_rom_hub -Mdir obj_dir -o tb_rom_hub
	./obj_dir/tb_rom_hub | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: rom_arbiter.sv
//==============================
// round-robin grant over slot requests
// one read in flight, busy until done
// slot 0 has first priority after reset
//==============================
`include "rom_settings.svh"

module rom_arbiter
    import rom_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic [`ROM_SLOTS-1:0]              req,
    input  logic [`ROM_SLOTS-1:0][`ROM_AW-1:0] addr_req,
    input  logic                               done,        // word returned
    output logic                               issue,       // one-cycle strobe
    output logic [`ROM_AW-1:0]                 issue_addr,
    output slot_idx_t                          issue_slot
);

    localparam int S = `ROM_SLOTS;

    logic      busy;
    slot_idx_t last;    // most recent grant
    slot_idx_t pick;
    logic      found;
    logic      grant;

    // scan starting just after the last grant
    always_comb begin
        int idx;
        pick  = last;
        found = 1'b0;
        for (int k = 1; k <= S; k++) begin
            idx = (int'(last) + k) % S;
            if (!found && req[idx]) begin
                pick  = slot_idx_t'(idx);
                found = 1'b1;
            end
        end
    end

    // a grant may land in the done cycle itself
    assign grant = (!busy || done) && found;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            issue <= 1'b0;
            last  <= slot_idx_t'(S - 1);
        end else begin
            issue <= grant;
            if (done)
                busy <= 1'b0;
            if (grant) begin
                busy <= 1'b1;   // wins over the clear above
                last <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant)
            issue_addr <= addr_req[pick];  // held for the whole read
    end

    assign issue_slot = last;

    if (`ROM_ASSERT_ON) begin : g_sva
        // reader completions must match an open read
        a_done_busy: assert property (@(posedge clk) disable iff (rst)
            done |-> busy)
            else $error("rom_arbiter: done while idle");
    end

endmodule

// File: rom_hub.sv
//==============================
// ROM access hub top level
// ROM_SLOTS requesters share one 32-bit ROM
// rom_data must follow rom_rd by ROM_LATENCY
//==============================
`include "rom_settings.svh"

module rom_hub
    import rom_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst,
    // requester side, one lane per slot
    input  logic [`ROM_SLOTS-1:0][`ROM_AW-1:0] addr,
    input  logic [`ROM_SLOTS-1:0]              addr_ok,
    input  logic [`ROM_SLOTS-1:0]              half,
    output logic [`ROM_SLOTS-1:0]              data_ok,
    output logic [`ROM_SLOTS-1:0][15:0]        dout,
    // external ROM
    output logic [`ROM_AW-3:0]                 rom_addr,
    output logic                               rom_rd,
    input  logic [31:0]                        rom_data
);

    logic [`ROM_SLOTS-1:0]              req;
    logic [`ROM_SLOTS-1:0][`ROM_AW-1:0] addr_req;
    logic [`ROM_SLOTS-1:0]              we;
    rom_word_u                          din;        // broadcast to all slots
    logic                               din_ok;
    logic                               done;
    logic                               issue;
    logic [`ROM_AW-1:0]                 issue_addr;
    slot_idx_t                          issue_slot;

    for (genvar i = 0; i < `ROM_SLOTS; i++) begin : g_slot
        rom_slot slot_i (
            .clk      (clk),
            .rst      (rst),
            .addr     (addr[i]),
            .addr_ok  (addr_ok[i]),
            .half     (half[i]),
            .din      (din),
            .din_ok   (din_ok),
            .we       (we[i]),
            .req      (req[i]),
            .addr_req (addr_req[i]),
            .data_ok  (data_ok[i]),
            .dout     (dout[i])
        );
    end

    rom_arbiter arb_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .addr_req   (addr_req),
        .done       (done),
        .issue      (issue),
        .issue_addr (issue_addr),
        .issue_slot (issue_slot)
    );

    rom_reader rd_i (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .issue_addr (issue_addr),
        .issue_slot (issue_slot),
        .rom_addr   (rom_addr),
        .rom_rd     (rom_rd),
        .rom_data   (rom_data),
        .din        (din),
        .din_ok     (din_ok),
        .we         (we),
        .done       (done)
    );

endmodule

// File: rom_pkg.sv
//==============================
// shared types for the ROM hub
// slot index width follows ROM_SLOTS
//==============================
`include "rom_settings.svh"

package rom_pkg;

    // one ROM word, read either as bytes or as halfwords
    // lane 0 sits in the low bits for both views
    typedef union packed {
        logic [3:0][7:0]  b;    // byte lanes, b[0] = bits 7..0
        logic [1:0][15:0] h;    // halfword lanes, h[0] = bits 15..0
    } rom_word_u;

    // slot number, wide enough for ROM_SLOTS
    localparam int SLOT_W = (`ROM_SLOTS > 1) ? $clog2(`ROM_SLOTS) : 1;

    typedef logic [SLOT_W-1:0] slot_idx_t;

endpackage

// File: rom_reader.sv
//==============================
// ROM read sequencer, fixed latency
// rom_data sampled ROM_LATENCY cycles after rom_rd
// din_ok one cycle later, we to one slot only
//==============================
`include "rom_settings.svh"

module rom_reader
    import rom_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue,
    input  logic [`ROM_AW-1:0]    issue_addr,
    input  slot_idx_t             issue_slot,
    output logic [`ROM_AW-3:0]    rom_addr,   // word address
    output logic                  rom_rd,
    input  logic [31:0]           rom_data,
    output rom_word_u             din,
    output logic                  din_ok,
    output logic [`ROM_SLOTS-1:0] we,
    output logic                  done
);

    localparam int LAT = `ROM_LATENCY;
    localparam int S   = `ROM_SLOTS;

    logic [LAT-1:0] pipe;     // one bit per cycle of ROM latency
    slot_idx_t      slot_q;   // owner of the read in flight
    logic           land;

    assign rom_rd   = issue;
    assign rom_addr = issue_addr[`ROM_AW-1:2];  // arbiter holds it while busy
    assign land     = pipe[LAT-1];              // rom_data valid now

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pipe   <= '0;
            din_ok <= 1'b0;
            we     <= '0;
        end else begin
            pipe   <= (pipe << 1) | LAT'(issue);
            din_ok <= land;
            we     <= land ? (S'(1) << slot_q) : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue)
            slot_q <= issue_slot;
        if (land)
            din <= rom_word_u'(rom_data);
    end

    assign done = din_ok;   // frees the arbiter

    if (`ROM_ASSERT_ON) begin : g_sva
        // the arbiter must wait for the previous word
        a_single_read: assert property (@(posedge clk) disable iff (rst)
            issue |-> (pipe == '0))
            else $error("rom_reader: issue during a pending read");
    end

endmodule

// File: rom_settings.svh
//==============================
// build-time settings for the ROM access hub
// ROM_LATENCY must be 1 or more
// ROM_SLOTS tested at 2, 4 and 8
// ROM_AW is a byte address width, at least 3
//==============================
`ifndef ROM_SETTINGS_SVH
`define ROM_SETTINGS_SVH

// number of requester slots sharing the ROM
`define ROM_SLOTS 4

// byte address width seen by requesters
`define ROM_AW 18

// cycles from rom_rd to valid rom_data
`define ROM_LATENCY 3

// 1 turns on the concurrent checks in the RTL
`define ROM_ASSERT_ON 1

`endif

// File: rom_slot.sv
//==============================
// per-requester two-entry word cache
// addr must stay put while a miss is pending
// the fill is tagged with the current addr
// dout is zero-extended on byte reads
//==============================
`include "rom_settings.svh"

module rom_slot
    import rom_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [`ROM_AW-1:0] addr,      // byte address
    input  logic               addr_ok,   // addr is valid
    input  logic               half,      // halfword read when high
    input  rom_word_u          din,       // shared word from reader
    input  logic               din_ok,
    input  logic               we,        // this slot was granted
    output logic               req,
    output logic [`ROM_AW-1:0] addr_req,  // word aligned
    output logic               data_ok,
    output logic [15:0]        dout
);

    logic               init;       // nothing cached yet
    logic               victim;     // entry replaced by the next fill
    logic [`ROM_AW-1:0] cached_addr0;
    logic [`ROM_AW-1:0] cached_addr1;
    rom_word_u          cached_data0;
    rom_word_u          cached_data1;
    logic               hit0;
    logic               hit1;
    logic               fill;
    rom_word_u          data_mux;
    logic [15:0]        dout_d;

    assign addr_req = {addr[`ROM_AW-1:2], 2'b00};

    // entries hold garbage until the first fill
    assign hit0 = !init && (addr_req == cached_addr0);
    assign hit1 = !init && (addr_req == cached_addr1);
    assign fill = we && din_ok;

    // init counts as a miss, and the fill cycle drops req
    assign req = addr_ok && !we && !(hit0 || hit1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init    <= 1'b1;
            victim  <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= addr_ok && (hit0 || hit1 || fill);
            if (fill) begin
                init <= 1'b0;
                if (!init)
                    victim <= ~victim;  // alternate only after the first fill
            end
        end
    end

    // cache payload, first fill loads both entries
    always_ff @(posedge clk) begin
        if (fill) begin
            if (init || !victim) begin
                cached_addr0 <= addr_req;
                cached_data0 <= din;
            end
            if (init || victim) begin
                cached_addr1 <= addr_req;
                cached_data1 <= din;
            end
        end
    end

    // fresh word goes straight out, saving a cycle on a miss
    assign data_mux = fill ? din : (hit0 ? cached_data0 : cached_data1);

    always_comb begin
        if (half)
            dout_d = data_mux.h[addr[1]];             // halfword lane by bit 1
        else
            dout_d = {8'h00, data_mux.b[addr[1:0]]};  // byte lane by bits 1..0
    end

    always_ff @(posedge clk) begin
        if (addr_ok)
            dout <= dout_d;   // holds the last value while idle
    end

    if (`ROM_ASSERT_ON) begin : g_sva
        // the reader must never strobe we on its own
        a_we_has_din: assert property (@(posedge clk) disable iff (rst)
            we |-> din_ok)
            else $error("rom_slot: we without din_ok");
        // a fill only lands on a slot that was still asking for it
        a_we_was_asked: assert property (@(posedge clk) disable iff (rst)
            we |-> $past(req))
            else $error("rom_slot: fill for a slot that was not requesting");
    end

endmodule

// File: rom_testdata.txt
# name        slot addr   half rd last exp
# rd = rom_rd count the record adds, last = 1 closes a batch of parallel requests
cold_s0       0    00100  0    1  1    00c0
cold_s1       1    02205  0    1  1    00c5
cold_s2       2    0330a  0    1  1    00ca
cold_s3       3    0440f  0    1  1    00cf
hit_same      0    00103  0    0  1    00c3
fill_second   0    00204  0    1  1    00c4
hit_first     0    00102  0    0  1    00c2
evict_first   0    00308  0    1  1    00c8
keep_second   0    00205  0    0  1    00c5
reload_first  0    00100  0    1  1    00c0
keep_third    0    0030b  0    0  1    00cb
half_lo       1    02204  1    0  1    c5c4
half_hi       1    02207  1    0  1    c7c6
half_miss     2    05550  1    1  1    9190
byte_after    2    05553  0    0  1    0093
all_s0        0    10010  0    1  0    00d0
all_s1        1    11121  1    1  0    e1e0
all_s2        2    12232  0    1  0    00f2
all_s3        3    13343  1    1  1    8382

// File: sim.f
+incdir+.
rom_pkg.sv
rom_slot.sv
rom_arbiter.sv
rom_reader.sv
rom_hub.sv
tb_rom_hub.sv

// File: tb_rom_hub.sv
//==============================
// testbench for the ROM hub, reads rom_testdata.txt from the run directory
// records of one batch use distinct slots and distinct words
// batch records assume the default of 4 slots
// ROM rule, byte at word w lane l = (4*w + l) ^ 8'hc0
//==============================
`include "rom_settings.svh"

module tb_rom_hub
    import rom_pkg::*;
();

    localparam int S   = `ROM_SLOTS;
    localparam int LAT = `ROM_LATENCY;
    localparam int AW  = `ROM_AW;

    logic                   clk = 1'b0;
    logic                   rst;
    logic [S-1:0][AW-1:0]   addr;
    logic [S-1:0]           addr_ok;
    logic [S-1:0]           half;
    logic [S-1:0]           data_ok;
    logic [S-1:0][15:0]     dout;
    logic [AW-3:0]          rom_addr;
    logic                   rom_rd;
    logic [31:0]            rom_data;
    logic [LAT-1:0]         rd_pipe = '0;   // ROM model, one bit per latency cycle
    logic [LAT-1:0][AW-3:0] addr_pipe;
    logic [7:0]             lfsr = 8'd16;   // picks idle gaps
    slot_idx_t              last_grant = slot_idx_t'(S - 1);  // arbiter starts at slot 0
    logic                   loaded = 1'b0;
    int                     n_checks = 0;
    int                     n_mismatch = 0;
    int                     n_other = 0;

    // one entry per data record
    string         rec_name [$];
    int            rec_slot [$];
    logic [AW-1:0] rec_addr [$];
    logic          rec_half [$];
    int            rec_rd   [$];   // rom_rd count this record adds to its batch
    logic          rec_last [$];   // closes a batch of parallel requests
    logic [15:0]   rec_exp  [$];

    rom_hub dut_i (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .addr_ok  (addr_ok),
        .half     (half),
        .data_ok  (data_ok),
        .dout     (dout),
        .rom_addr (rom_addr),
        .rom_rd   (rom_rd),
        .rom_data (rom_data)
    );

    always #50 clk = ~clk;

    // whole ROM word from the rule
    function automatic rom_word_u rom_word(input logic [AW-3:0] w);
        rom_word_u wd;
        for (int l = 0; l < 4; l++)
            wd.b[l] = 8'(int'(w) * 4 + l) ^ 8'hc0;
        return wd;
    endfunction

    // 4*w + lane is the byte address, so each byte is its low address bits flipped
    function automatic logic [15:0] rule_dout(input logic [AW-1:0] a, input logic h);
        if (h)
            return {8'(a | 1) ^ 8'hc0, 8'(a & ~1) ^ 8'hc0};
        return {8'h00, 8'(a) ^ 8'hc0};
    endfunction

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};   // taps 8,6,5,4
    endfunction

    // first waiting slot after prev, wrapping around
    function automatic slot_idx_t next_grant(input slot_idx_t prev, input logic [S-1:0] pend);
        slot_idx_t nxt;
        nxt = prev;
        for (int k = S; k >= 1; k--)
            if (pend[(int'(prev) + k) % S])
                nxt = slot_idx_t'((int'(prev) + k) % S);
        return nxt;
    endfunction

    // ROM model, data valid LAT cycles after rom_rd
    always @(posedge clk) begin
        if (rom_rd && rd_pipe != '0) begin
            n_other++;
            $display("rom_rd at word %h while a ROM read is still outstanding", rom_addr);
        end
        rd_pipe      <= (rd_pipe << 1) | LAT'(rom_rd);
        addr_pipe[0] <= rom_addr;
        for (int k = 1; k < LAT; k++)
            addr_pipe[k] <= addr_pipe[k-1];
    end

    assign rom_data = rd_pipe[LAT-1] ? rom_word(addr_pipe[LAT-1]) : 32'h0;

    task automatic check_dout(input string test, input logic [15:0] exp, input logic [15:0] act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("mismatch %s dout expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic check_word(input string test, input rom_word_u exp, input rom_word_u act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("mismatch %s word expected %h actual %h", test, exp, act);
        end
    endtask

    task automatic check_slot(input string test, input slot_idx_t exp, input slot_idx_t act);
        n_checks++;
        if (act !== exp) begin
            n_mismatch++;
            $display("mismatch %s granted slot expected %0d actual %0d", test, exp, act);
        end
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            n_mismatch++;
            $display("mismatch %s rom_rd count expected %0d actual %0d", test, exp, act);
        end
    endtask

    task automatic check_result(input int r, input logic [15:0] act);
        rom_word_u     want;
        rom_word_u     seen;
        logic [AW-1:0] a;
        a = rec_addr[r];
        if (rec_exp[r] != rule_dout(a, rec_half[r])) begin
            n_other++;
            $display("%s: data file value %h breaks the ROM rule", rec_name[r], rec_exp[r]);
        end
        check_dout(rec_name[r], rec_exp[r], act);
        want = rom_word(a[AW-1:2]);
        seen = want;            // lanes not read are taken as expected
        if (rec_half[r])
            seen.h[a[1]] = act;
        else
            seen.b[a[1:0]] = act[7:0];
        check_word(rec_name[r], want, seen);
    endtask

    task automatic load_records();
        int    fd;
        string line;
        string nm;
        int    sl, ad, hf, rd, ls, ex;
        fd = $fopen("rom_testdata.txt", "r");
        if (fd == 0) begin
            n_other++;
            $display("could not open rom_testdata.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line[0] != "#" &&
                $sscanf(line, "%s %d %h %d %d %d %h", nm, sl, ad, hf, rd, ls, ex) == 7) begin
                rec_name.push_back(nm);
                rec_slot.push_back(sl);
                rec_addr.push_back(AW'(ad));
                rec_half.push_back(hf != 0);
                rec_rd.push_back(rd);
                rec_last.push_back(ls != 0);
                rec_exp.push_back(16'(ex));
            end
        end
        $fclose(fd);
    endtask

    // launch records first..last together, then wait for every data_ok
    task automatic run_batch(input int first, input int last);
        logic [S-1:0] wait_rd;   // slots still owed a rom_rd
        logic [S-1:0] wait_ok;   // slots still owed data_ok
        int           owner [S];
        int           want;
        int           reads;
        int           g;
        wait_rd = '0;
        wait_ok = '0;
        want    = 0;
        reads   = 0;
        for (int r = first; r <= last; r++) begin
            addr[rec_slot[r]]    = rec_addr[r];
            half[rec_slot[r]]    = rec_half[r];
            addr_ok[rec_slot[r]] = 1'b1;
            wait_ok[rec_slot[r]] = 1'b1;
            wait_rd[rec_slot[r]] = (rec_rd[r] != 0);
            owner[rec_slot[r]]   = r;
            want += rec_rd[r];
        end
        while (wait_ok != '0) begin
            @(posedge clk);
            #1;
            if (rom_rd) begin
                reads++;
                g = -1;
                for (int k = 0; k < S; k++)
                    if (wait_rd[k] && rom_addr == addr[k][AW-1:2])
                        g = k;
                if (g < 0) begin
                    n_other++;
                    $display("rom_rd at word %h that no waiting slot asked for", rom_addr);
                end else begin
                    check_slot(rec_name[owner[g]], next_grant(last_grant, wait_rd),
                               slot_idx_t'(g));
                    last_grant = slot_idx_t'(g);
                    wait_rd[g] = 1'b0;
                end
            end
            for (int k = 0; k < S; k++)
                if (wait_ok[k] && data_ok[k]) begin
                    check_result(owner[k], dout[k]);
                    addr_ok[k] = 1'b0;   // the next idle edge clears data_ok
                    wait_ok[k] = 1'b0;
                end
        end
        check_count(rec_name[last], want, reads);
    endtask

    initial begin
        int first;
        int r;
        int bits;
        rst     = 1'b1;
        addr    = '0;
        addr_ok = '0;
        half    = '0;
        load_records();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        r = 0;
        while (r < rec_name.size()) begin
            first = r;
            while (!rec_last[r] && r < rec_name.size() - 1)
                r++;
            run_batch(first, r);
            r++;
            bits = 0;
            for (int k = 0; k < 2; k++) begin   // two LFSR bits, gap of 1 to 4 cycles
                lfsr = lfsr_step(lfsr);
                bits = bits * 2 + int'(lfsr[0]);
            end
            repeat (bits + 1) @(posedge clk);
            #1;
        end
        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0 && n_checks > 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    // watchdog, budget per record covers a full round of misses
    initial begin
        int limit;
        wait (loaded);
        limit = 16 + rec_name.size() * (6 + S * (LAT + 4));
        repeat (limit) @(posedge clk);
        n_other++;
        $display("watchdog expired after %0d cycles with a request still open", limit);
        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
        $display("Test failed");
        $finish;
    end

endmodule
